//--- csr_core_top.f
+incdir+source
source/csr_pkg.sv
source/csr_access_port.sv
source/csr_exc_regs.sv
source/csr_timer.sv
source/csr_core_top.sv
test/csr_core_tb.sv

//--- source/csr_access_port.sv
`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_access_port (
  input  logic                        clk,
  input  logic                        rst_n,
  input  csr_pkg::csr_rd_req_t        rd_req_i,
  input  csr_pkg::csr_wr_req_t        wr_req_i,
  input  logic                        stall_i,
  input  csr_pkg::csr_view_t          view_i,
  input  csr_pkg::timer_view_t        tview_i,
  input  logic [63:0]                 counter_i,
  input  logic [3:0][`CSR_DATA_W-1:0] save_i,
  output csr_pkg::csr_wr_t            wr_o,
  output logic [`CSR_DATA_W-1:0]      csr_r_data_o
);

  import csr_pkg::*;

  logic [7:0]             rd_idx;
  logic [`CSR_DATA_W-1:0] rd_data;

  // only the low byte of the address is decoded
  assign rd_idx = rd_req_i.addr[7:0];

  always_comb begin
    rd_data = '0;
    case (rd_req_i.rdcnt)
      RDCNT_VLOW:  rd_data = counter_i[31:0];
      RDCNT_VHIGH: rd_data = counter_i[63:32];
      RDCNT_ID:    rd_data = tview_i.tid;
      default: begin
        case (rd_idx)
          8'(`CSR_CRMD):   rd_data = view_i.crmd;
          8'(`CSR_PRMD):   rd_data = view_i.prmd;
          8'(`CSR_ESTAT):  rd_data = view_i.estat;
          8'(`CSR_ERA):    rd_data = view_i.era;
          8'(`CSR_EENTRY): rd_data = view_i.eentry;
          8'(`CSR_SAVE0):  rd_data = save_i[0];
          8'(`CSR_SAVE1):  rd_data = save_i[1];
          8'(`CSR_SAVE2):  rd_data = save_i[2];
          8'(`CSR_SAVE3):  rd_data = save_i[3];
          8'(`CSR_TID):    rd_data = tview_i.tid;
          8'(`CSR_TCFG):   rd_data = tview_i.tcfg;
          8'(`CSR_TVAL):   rd_data = tview_i.tval;
          // ticlr reads as zero too
          default:         rd_data = '0;
        endcase
      end
    endcase
  end

  // read data is held while stalled
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      csr_r_data_o <= '0;
    end else if (!stall_i) begin
      csr_r_data_o <= rd_data;
    end
  end

  // merge with the last read value outside the mask
  always_comb begin
    wr_o.we   = wr_req_i.we && !stall_i;
    wr_o.addr = wr_req_i.addr;
    wr_o.data = (csr_r_data_o & ~wr_req_i.mask) | (wr_req_i.data & wr_req_i.mask);
  end

  // a stalled cycle neither writes nor moves the read data
  assert property (@(posedge clk) disable iff (!rst_n)
    stall_i |-> (!wr_o.we ##1 $stable(csr_r_data_o)))
    else $error("csr access port: write or read update during stall");

endmodule

//--- source/csr_core_top.sv
`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_core_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  csr_pkg::csr_rd_req_t   rd_req_i,
  input  csr_pkg::csr_wr_req_t   wr_req_i,
  input  csr_pkg::excp_req_t     excp_i,
  input  logic [7:0]             int_i,
  input  logic                   stall_i,
  output logic [`CSR_DATA_W-1:0] csr_r_data_o,
  output csr_pkg::csr_view_t     csr_o
);

  import csr_pkg::*;

  csr_wr_t                     wr;
  timer_view_t                 tview;
  logic [63:0]                 counter;
  logic                        timer_irq;
  logic [3:0][`CSR_DATA_W-1:0] save;

  csr_access_port u_access_port (
    .clk          (clk),
    .rst_n        (rst_n),
    .rd_req_i     (rd_req_i),
    .wr_req_i     (wr_req_i),
    .stall_i      (stall_i),
    .view_i       (csr_o),
    .tview_i      (tview),
    .counter_i    (counter),
    .save_i       (save),
    .wr_o         (wr),
    .csr_r_data_o (csr_r_data_o)
  );

  // register view goes straight out to the pipeline
  csr_exc_regs u_exc_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr_i        (wr),
    .excp_i      (excp_i),
    .int_i       (int_i),
    .timer_irq_i (timer_irq),
    .save_o      (save),
    .view_o      (csr_o)
  );

  csr_timer u_timer (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr_i        (wr),
    .tview_o     (tview),
    .counter_o   (counter),
    .timer_irq_o (timer_irq)
  );

endmodule

//--- source/csr_exc_regs.sv
`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_exc_regs (
  input  logic                        clk,
  input  logic                        rst_n,
  input  csr_pkg::csr_wr_t            wr_i,
  input  csr_pkg::excp_req_t          excp_i,
  input  logic [7:0]                  int_i,
  input  logic                        timer_irq_i,
  output logic [3:0][`CSR_DATA_W-1:0] save_o,
  output csr_pkg::csr_view_t          view_o
);

  logic                        excp_valid;
  logic                        ertn_valid;
  logic                        crmd_we;
  logic                        prmd_we;
  logic                        estat_we;
  logic                        era_we;
  logic                        eentry_we;
  logic [3:0]                  save_we;

  logic [`CSR_DATA_W-1:0]      crmd_q;
  logic [`CSR_DATA_W-1:0]      prmd_q;
  logic [`CSR_DATA_W-1:0]      era_q;
  logic [`CSR_DATA_W-1:0]      eentry_q;
  logic [`CSR_DATA_W-1:0]      estat;
  logic [1:0]                  is_sw_q;
  logic [7:0]                  is_hw_q;
  logic [5:0]                  ecode_q;
  logic [8:0]                  esubcode_q;
  logic [3:0][`CSR_DATA_W-1:0] save_q;

  assign excp_valid = excp_i.valid;
  assign ertn_valid = excp_i.ertn;

  assign crmd_we   = wr_i.we && (wr_i.addr == `CSR_CRMD);
  assign prmd_we   = wr_i.we && (wr_i.addr == `CSR_PRMD);
  assign estat_we  = wr_i.we && (wr_i.addr == `CSR_ESTAT);
  assign era_we    = wr_i.we && (wr_i.addr == `CSR_ERA);
  assign eentry_we = wr_i.we && (wr_i.addr == `CSR_EENTRY);

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      save_we[i] = wr_i.we && (wr_i.addr == `CSR_SAVE0 + 14'(i));
    end
  end

  // software write wins over ertn, ertn over exception entry
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      crmd_q <= `CRMD_RESET;
    end else if (crmd_we) begin
      crmd_q[`CRMD_PLV] <= wr_i.data[`CRMD_PLV];
      crmd_q[`CRMD_IE]  <= wr_i.data[`CRMD_IE];
      crmd_q[`CRMD_DA]  <= wr_i.data[`CRMD_DA];
    end else if (ertn_valid) begin
      crmd_q[`CRMD_PLV] <= prmd_q[`PRMD_PPLV];
      crmd_q[`CRMD_IE]  <= prmd_q[`PRMD_PIE];
    end else if (excp_valid) begin
      crmd_q[`CRMD_PLV] <= 2'b00;
      crmd_q[`CRMD_IE]  <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      prmd_q <= '0;
    end else if (prmd_we) begin
      prmd_q[`PRMD_PPLV] <= wr_i.data[`PRMD_PPLV];
      prmd_q[`PRMD_PIE]  <= wr_i.data[`PRMD_PIE];
    end else if (excp_valid && !ertn_valid) begin
      prmd_q[`PRMD_PPLV] <= crmd_q[`CRMD_PLV];
      prmd_q[`PRMD_PIE]  <= crmd_q[`CRMD_IE];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      era_q <= '0;
    end else if (era_we) begin
      era_q <= wr_i.data;
    end else if (excp_valid && !ertn_valid) begin
      era_q <= excp_i.pc;
    end
  end

  // low six bits of eentry stay zero
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      eentry_q <= '0;
    end else if (eentry_we) begin
      eentry_q[`EENTRY_VA] <= wr_i.data[`EENTRY_VA];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      is_sw_q    <= '0;
      is_hw_q    <= '0;
      ecode_q    <= '0;
      esubcode_q <= '0;
    end else begin
      is_hw_q <= int_i;
      if (estat_we) begin
        is_sw_q <= wr_i.data[`ESTAT_IS_SW];
      end
      if (excp_valid && !ertn_valid) begin
        ecode_q    <= excp_i.ecode;
        esubcode_q <= excp_i.esubcode;
      end
    end
  end

  // timer pending bit is not stored here
  always_comb begin
    estat                  = '0;
    estat[`ESTAT_IS_SW]    = is_sw_q;
    estat[`ESTAT_IS_HW]    = is_hw_q;
    estat[`ESTAT_TI]       = timer_irq_i;
    estat[`ESTAT_ECODE]    = ecode_q;
    estat[`ESTAT_ESUBCODE] = esubcode_q;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      save_q <= '0;
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (save_we[i]) begin
          save_q[i] <= wr_i.data;
        end
      end
    end
  end

  assign save_o        = save_q;
  assign view_o.crmd   = crmd_q;
  assign view_o.prmd   = prmd_q;
  assign view_o.estat  = estat;
  assign view_o.era    = era_q;
  assign view_o.eentry = eentry_q;

  assert property (@(posedge clk) disable iff (!rst_n)
    !(excp_i.valid && excp_i.ertn))
    else $error("csr exc regs: exception and ertn in the same cycle");

endmodule

//--- source/csr_macros.svh
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

// bus widths
`define CSR_ADDR_W 14
`define CSR_DATA_W 32

// csr addresses
`define CSR_CRMD   14'h000
`define CSR_PRMD   14'h001
`define CSR_ESTAT  14'h005
`define CSR_ERA    14'h006
`define CSR_EENTRY 14'h00c
`define CSR_SAVE0  14'h030
`define CSR_SAVE1  14'h031
`define CSR_SAVE2  14'h032
`define CSR_SAVE3  14'h033
`define CSR_TID    14'h040
`define CSR_TCFG   14'h041
`define CSR_TVAL   14'h042
`define CSR_TICLR  14'h044

// crmd / prmd fields
`define CRMD_PLV   1:0
`define CRMD_IE    2
`define CRMD_DA    3
`define CRMD_RESET 32'h0000_0008
`define PRMD_PPLV  1:0
`define PRMD_PIE   2

// estat fields
`define ESTAT_IS_SW    1:0
`define ESTAT_IS_HW    9:2
`define ESTAT_TI       11
`define ESTAT_ECODE    21:16
`define ESTAT_ESUBCODE 30:22

// timer fields
`define TCFG_EN       0
`define TCFG_PERIODIC 1
`define TCFG_INITVAL  31:2
`define TICLR_CLR     0

`define EENTRY_VA 31:6

`endif

//--- source/csr_pkg.sv
`include "csr_macros.svh"

package csr_pkg;

  // counter read select, overrides the csr address
  typedef enum logic [1:0] {
    RDCNT_NONE  = 2'd0,
    RDCNT_ID    = 2'd1,
    RDCNT_VLOW  = 2'd2,
    RDCNT_VHIGH = 2'd3
  } rdcnt_e;

  typedef enum logic [5:0] {
    ECODE_INT = 6'h00,
    ECODE_SYS = 6'h0b,
    ECODE_BRK = 6'h0c,
    ECODE_INE = 6'h0d
  } ecode_e;

  typedef struct packed {
    logic [`CSR_ADDR_W-1:0] addr;
    rdcnt_e                 rdcnt;
  } csr_rd_req_t;

  // raw write from the pipeline
  typedef struct packed {
    logic                   we;
    logic [`CSR_ADDR_W-1:0] addr;
    logic [`CSR_DATA_W-1:0] mask;
    logic [`CSR_DATA_W-1:0] data;
  } csr_wr_req_t;

  // merged write, already gated by the stall
  typedef struct packed {
    logic                   we;
    logic [`CSR_ADDR_W-1:0] addr;
    logic [`CSR_DATA_W-1:0] data;
  } csr_wr_t;

  typedef struct packed {
    logic                   valid;
    ecode_e                 ecode;
    logic [8:0]             esubcode;
    logic [`CSR_DATA_W-1:0] pc;
    logic                   ertn;
  } excp_req_t;

  typedef struct packed {
    logic [`CSR_DATA_W-1:0] crmd;
    logic [`CSR_DATA_W-1:0] prmd;
    logic [`CSR_DATA_W-1:0] estat;
    logic [`CSR_DATA_W-1:0] era;
    logic [`CSR_DATA_W-1:0] eentry;
  } csr_view_t;

  typedef struct packed {
    logic [`CSR_DATA_W-1:0] tid;
    logic [`CSR_DATA_W-1:0] tcfg;
    logic [`CSR_DATA_W-1:0] tval;
  } timer_view_t;

endpackage

//--- source/csr_timer.sv
`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_timer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  csr_pkg::csr_wr_t     wr_i,
  output csr_pkg::timer_view_t tview_o,
  output logic [63:0]          counter_o,
  output logic                 timer_irq_o
);

  logic                   tid_we;
  logic                   tcfg_we;
  logic                   ticlr_we;
  logic                   tval_zero;
  logic [`CSR_DATA_W-1:0] tid_q;
  logic [`CSR_DATA_W-1:0] tcfg_q;
  logic [`CSR_DATA_W-1:0] tval_q;
  logic                   timer_en;
  logic                   pend_q;
  logic [63:0]            counter_q;

  assign tid_we   = wr_i.we && (wr_i.addr == `CSR_TID);
  assign tcfg_we  = wr_i.we && (wr_i.addr == `CSR_TCFG);
  assign ticlr_we = wr_i.we && (wr_i.addr == `CSR_TICLR);

  // expiry of an enabled timer
  assign tval_zero = timer_en && (tval_q == '0);

  // free-running stable counter
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      counter_q <= '0;
    end else begin
      counter_q <= counter_q + 64'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tid_q  <= '0;
      tcfg_q <= '0;
    end else begin
      if (tid_we) begin
        tid_q <= wr_i.data;
      end
      if (tcfg_we) begin
        tcfg_q <= wr_i.data;
      end
    end
  end

  // one-shot timers stop after expiring
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      timer_en <= 1'b0;
      tval_q   <= '0;
    end else if (tcfg_we) begin
      timer_en <= wr_i.data[`TCFG_EN];
      tval_q   <= {wr_i.data[`TCFG_INITVAL], 2'b00};
    end else if (tval_zero) begin
      timer_en <= tcfg_q[`TCFG_PERIODIC];
      tval_q   <= tcfg_q[`TCFG_PERIODIC] ? {tcfg_q[`TCFG_INITVAL], 2'b00} : '1;
    end else if (timer_en) begin
      tval_q <= tval_q - 32'd1;
    end
  end

  // clear wins over a same-cycle expiry
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pend_q <= 1'b0;
    end else if (ticlr_we && wr_i.data[`TICLR_CLR]) begin
      pend_q <= 1'b0;
    end else if (tval_zero) begin
      pend_q <= 1'b1;
    end
  end

  assign timer_irq_o  = pend_q;
  assign counter_o    = counter_q;
  assign tview_o.tid  = tid_q;
  assign tview_o.tcfg = tcfg_q;
  assign tview_o.tval = tval_q;

  assert property (@(posedge clk) disable iff (!rst_n)
    $rose(pend_q) |-> $past(timer_en))
    else $error("csr timer: pending bit set while the timer was disabled");

endmodule

//--- test/csr_core_tb.sv
`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_core_tb;

  import csr_pkg::*;

  logic                   clk;
  logic                   rst_n;
  csr_rd_req_t            rd_req;
  csr_wr_req_t            wr_req;
  excp_req_t              excp;
  logic [7:0]             int_lines;
  logic                   stall;
  logic [`CSR_DATA_W-1:0] r_data;
  csr_view_t              view;

  logic [31:0] lfsr;
  int          test_errors;
  int          pass_count;
  int          fail_count;

  csr_core_top dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .rd_req_i     (rd_req),
    .wr_req_i     (wr_req),
    .excp_i       (excp),
    .int_i        (int_lines),
    .stall_i      (stall),
    .csr_r_data_o (r_data),
    .csr_o        (view)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] galois_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = galois_step(lfsr);
    end
  endtask

  // inputs change 1 ns after the edge
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
    else begin
      $display("Error: %s expected %h actual %h", name, expected, actual);
      test_errors++;
    end
  endtask

  task automatic read_csr(input logic [13:0] addr, output logic [31:0] data);
    rd_req.addr  = addr;
    rd_req.rdcnt = RDCNT_NONE;
    tick();
    data = r_data;
  endtask

  task automatic read_cnt(input rdcnt_e sel, output logic [31:0] data);
    rd_req.rdcnt = sel;
    tick();
    data = r_data;
  endtask

  // merge uses whatever the last read left on r_data
  task automatic write_csr(input logic [13:0] addr, input logic [31:0] mask,
                           input logic [31:0] data);
    wr_req.we   = 1'b1;
    wr_req.addr = addr;
    wr_req.mask = mask;
    wr_req.data = data;
    tick();
    wr_req.we = 1'b0;
  endtask

  task automatic finish_test(input string name);
    if (test_errors == 0) begin
      pass_count++;
      $display("test %s: ok", name);
    end else begin
      fail_count++;
      $display("test %s: %0d errors", name, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic test_reset();
    logic [31:0] rd;
    read_csr(`CSR_CRMD, rd);
    check_value("reset crmd", `CRMD_RESET, rd);
    read_csr(`CSR_PRMD, rd);
    check_value("reset prmd", 32'd0, rd);
    read_csr(`CSR_ERA, rd);
    check_value("reset era", 32'd0, rd);
    read_csr(`CSR_SAVE0, rd);
    check_value("reset save0", 32'd0, rd);
    check_value("reset view crmd", `CRMD_RESET, view.crmd);
  endtask

  task automatic test_save();
    logic [13:0] addr;
    logic [31:0] old;
    logic [31:0] data;
    logic [31:0] mask;
    logic [31:0] rd;
    logic [31:0] expected;
    for (int i = 0; i < 4; i++) begin
      addr = `CSR_SAVE0 + 14'(i);
      read_csr(addr, old);
      take_bits(32, data);
      take_bits(32, mask);
      write_csr(addr, mask, data);
      expected = (old & ~mask) | (data & mask);
      read_csr(addr, rd);
      check_value("save readback", expected, rd);
      // stalled write plus a read of another register
      stall        = 1'b1;
      rd_req.addr  = `CSR_CRMD;
      wr_req.we    = 1'b1;
      wr_req.addr  = addr;
      wr_req.mask  = '1;
      wr_req.data  = ~expected;
      tick();
      stall     = 1'b0;
      wr_req.we = 1'b0;
      check_value("save stall hold", expected, r_data);
      read_csr(addr, rd);
      check_value("save stall no write", expected, rd);
    end
  endtask

  task automatic test_exception();
    logic [31:0] crmd_user;
    logic [31:0] crmd_exc;
    logic [31:0] prmd_exp;
    logic [31:0] pc;
    logic [31:0] entry;
    logic [31:0] entry_exp;
    logic [31:0] rd;
    crmd_user            = `CRMD_RESET;
    crmd_user[`CRMD_PLV] = 2'd3;
    crmd_user[`CRMD_IE]  = 1'b1;
    crmd_exc             = crmd_user;
    crmd_exc[`CRMD_PLV]  = 2'd0;
    crmd_exc[`CRMD_IE]   = 1'b0;
    prmd_exp             = '0;
    prmd_exp[`PRMD_PPLV] = 2'd3;
    prmd_exp[`PRMD_PIE]  = 1'b1;
    take_bits(32, pc);
    // only the entry address bits of eentry are writable
    take_bits(32, entry);
    entry_exp             = '0;
    entry_exp[`EENTRY_VA] = entry[`EENTRY_VA];
    write_csr(`CSR_EENTRY, '1, entry);
    read_csr(`CSR_EENTRY, rd);
    check_value("eentry readback", entry_exp, rd);
    check_value("eentry view", entry_exp, view.eentry);
    write_csr(`CSR_CRMD, '1, crmd_user);
    excp.valid    = 1'b1;
    excp.ecode    = ECODE_SYS;
    excp.esubcode = '0;
    excp.pc       = pc;
    excp.ertn     = 1'b0;
    tick();
    excp.valid = 1'b0;
    read_csr(`CSR_PRMD, rd);
    check_value("entry prmd", prmd_exp, rd);
    read_csr(`CSR_CRMD, rd);
    check_value("entry crmd", crmd_exc, rd);
    read_csr(`CSR_ERA, rd);
    check_value("entry era", pc, rd);
    read_csr(`CSR_ESTAT, rd);
    check_value("entry ecode", 32'(ECODE_SYS), 32'(rd[`ESTAT_ECODE]));
    check_value("entry view prmd", prmd_exp, view.prmd);
    check_value("entry view crmd", crmd_exc, view.crmd);
    check_value("entry view era", pc, view.era);
    check_value("entry view ecode", 32'(ECODE_SYS), 32'(view.estat[`ESTAT_ECODE]));
    excp.ertn = 1'b1;
    tick();
    excp.ertn = 1'b0;
    read_csr(`CSR_CRMD, rd);
    check_value("ertn crmd", crmd_user, rd);
    check_value("ertn view crmd", crmd_user, view.crmd);
  endtask

  task automatic test_timer();
    logic [31:0] tcfg;
    logic [31:0] ticlr;
    logic [31:0] k;
    logic [31:0] v1;
    logic [31:0] rd;
    logic        seen;
    int          waited;
    tcfg                 = '0;
    tcfg[`TCFG_EN]       = 1'b1;
    tcfg[`TCFG_INITVAL]  = 30'd4;
    ticlr                = '0;
    ticlr[`TICLR_CLR]    = 1'b1;
    take_bits(3, k);
    k = k + 32'd1;
    write_csr(`CSR_TCFG, '1, tcfg);
    read_csr(`CSR_TVAL, v1);
    check_value("tval load", 32'd16, v1);
    repeat (k) tick();
    check_value("tval countdown", k, v1 - r_data);
    seen        = 1'b0;
    waited      = 0;
    rd_req.addr = `CSR_ESTAT;
    while (!seen && waited < 64) begin
      tick();
      seen = r_data[`ESTAT_TI];
      waited++;
    end
    if (!seen) begin
      $display("timeout: timer interrupt did not reach ESTAT bit 11 in 64 cycles");
      test_errors++;
    end
    write_csr(`CSR_TICLR, '1, ticlr);
    read_csr(`CSR_ESTAT, rd);
    check_value("estat ti cleared", 32'd0, 32'(rd[`ESTAT_TI]));
  endtask

  task automatic test_counter();
    logic [31:0] k;
    logic [31:0] c1;
    logic [31:0] tid;
    logic [31:0] rd;
    take_bits(4, k);
    k = k + 32'd1;
    read_cnt(RDCNT_VLOW, c1);
    repeat (k) tick();
    check_value("counter delta", k, r_data - c1);
    read_cnt(RDCNT_VHIGH, rd);
    check_value("counter high", 32'd0, rd);
    take_bits(32, tid);
    write_csr(`CSR_TID, '1, tid);
    read_cnt(RDCNT_ID, rd);
    check_value("counter id", tid, rd);
    rd_req.rdcnt = RDCNT_NONE;
  endtask

  task automatic test_irq();
    logic [31:0] lines;
    logic [31:0] rd;
    logic [31:0] data;
    logic [31:0] mask;
    logic [31:0] merged;
    logic [31:0] expected;
    take_bits(8, lines);
    int_lines = lines[7:0];
    tick();
    check_value("estat hw view", lines, 32'(view.estat[`ESTAT_IS_HW]));
    read_csr(`CSR_ESTAT, rd);
    check_value("estat hw read", lines, 32'(rd[`ESTAT_IS_HW]));
    take_bits(32, data);
    take_bits(32, mask);
    merged                  = (rd & ~mask) | (data & mask);
    expected                = rd;
    expected[`ESTAT_IS_SW]  = merged[`ESTAT_IS_SW];
    write_csr(`CSR_ESTAT, mask, data);
    read_csr(`CSR_ESTAT, rd);
    check_value("estat sw write", expected, rd);
  endtask

  initial begin
    rst_n       = 1'b0;
    rd_req      = '0;
    wr_req      = '0;
    excp        = '0;
    int_lines   = '0;
    stall       = 1'b0;
    lfsr        = 32'd94;
    test_errors = 0;
    pass_count  = 0;
    fail_count  = 0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_reset();
    finish_test("reset values");
    test_save();
    finish_test("masked write and stall");
    test_exception();
    finish_test("exception entry and return");
    test_timer();
    finish_test("one-shot timer");
    test_counter();
    finish_test("stable counter and id");
    test_irq();
    finish_test("interrupt lines");
    $display("tests passed %0d failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
